/* source/snes_bus_pkg.sv */
package snes_bus_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////
  localparam int snes_addr_w = 24;
  localparam int snes_data_w = 8;

  localparam int sync_depth = 8;  // control line shift registers
  localparam int bus_stages = 3;  // address and data stage arrays

  // stages six down to one, oldest sample on the left
  localparam logic [5:0] edge_rise_pat = 6'b000001;
  localparam logic [5:0] edge_fall_pat = 6'b111110;
  localparam logic [5:0] pulse_end_pat = 6'b000011;

  // 1 ms at 96 MHz without a CPU clock edge
  localparam int snes_dead_timeout = 96000;
  localparam int dead_cnt_w = $clog2(snes_dead_timeout + 2);

  // LoROM, bank bits land right above the 32k in-bank offset
  localparam int lorom_bank_shift = 15;

endpackage

/* source/rom_pkg.sv */
package rom_pkg;

  localparam int rom_addr_w = 24;  // byte address
  localparam int rom_word_w = 16;
  localparam int rom_byte_w = rom_word_w / 2;

  // memory cycle, counted down from here to zero
  localparam int rom_cycle_len = 8;
  localparam int rom_delay_w = $clog2(rom_cycle_len + 1);

  ////////////////////////////////////////
  // arbiter states, one-hot
  ////////////////////////////////////////
  typedef enum logic [4:0] {
    st_idle    = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end  = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end  = 5'b10000
  } arb_state_t;

  // one ROM address seen as bytes or as 16-bit words
  typedef struct packed {
    logic [rom_addr_w-2:0] word;  // word index on the ROM pins
    logic                  lane_lo;  // 1 selects the low byte
  } rom_word_addr_t;

  typedef union packed {
    logic [rom_addr_w-1:0] byte_addr;
    rom_word_addr_t        w;
  } rom_addr_u;

endpackage

/* source/snes_bus_if.sv */
`timescale 1ns/100ps

// conditioned SNES bus, one driver and any number of readers
interface snes_bus_if
  import snes_bus_pkg::*;
();

  logic [snes_addr_w-1:0] addr;
  logic [snes_data_w-1:0] data_in;

  logic read;         // active low
  logic write;        // active low
  logic romsel;       // active low
  logic cpu_clk;
  logic read_narrow;  // low only while read is low in both windows

  // single cycle strobes
  logic cycle_start;
  logic pulse_end;
  logic rd_start;

  modport sync (
    output addr, data_in, read, write, romsel, cpu_clk, read_narrow,
    output cycle_start, pulse_end, rd_start
  );

  modport user (
    input addr, data_in, read, write, romsel, cpu_clk, read_narrow,
    input cycle_start, pulse_end, rd_start
  );

endinterface

/* source/rom_port_if.sv */
`timescale 1ns/100ps

// MCU side of the ROM bus, arbiter to multiplexer
interface rom_port_if
  import rom_pkg::*;
();

  rom_addr_u               addr;     // latched MCU address
  logic                    mcu_hit;  // an MCU access owns the ROM bus
  logic                    mcu_we;   // write address phase
  logic [rom_byte_w-1:0]   rd_byte;  // ROM byte on the selected lane

  modport arb (
    output addr, mcu_hit, mcu_we,
    input  rd_byte
  );

  modport mux (
    input  addr, mcu_hit, mcu_we,
    output rd_byte
  );

endinterface

/* source/snes_bus_sync.sv */
`timescale 1ns/100ps

module snes_bus_sync
  import snes_bus_pkg::*;
(
  input  logic                   CLK2,
  input  logic                   arst_n,
  input  logic [snes_addr_w-1:0] snes_addr_in,
  input  logic [snes_data_w-1:0] snes_data_in,
  input  logic                   snes_read_in,
  input  logic                   snes_write_in,
  input  logic                   snes_romsel_in,
  input  logic                   snes_cpu_clk_in,
  snes_bus_if.sync               bus
);

  logic [sync_depth-1:0]  read_r;
  logic [sync_depth-1:0]  write_r;
  logic [sync_depth-1:0]  romsel_r;
  logic [sync_depth-1:0]  cpu_clk_r;
  logic [sync_depth-1:0]  pulse_r;
  logic [snes_addr_w-1:0] addr_r [bus_stages];
  logic [snes_data_w-1:0] data_r [bus_stages];
  logic                   pulse_in;
  logic                   read_lvl;

  // bus idle phase between two accesses
  assign pulse_in = snes_read_in & snes_write_in & ~snes_cpu_clk_in;

  ////////////////////////////////////////
  // input shift registers
  ////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_r    <= '1;
      write_r   <= '1;
      romsel_r  <= '1;
      cpu_clk_r <= '0;
      pulse_r   <= '1;
    end else begin
      read_r    <= {read_r[sync_depth-2:0], snes_read_in};
      write_r   <= {write_r[sync_depth-2:0], snes_write_in};
      romsel_r  <= {romsel_r[sync_depth-2:0], snes_romsel_in};
      cpu_clk_r <= {cpu_clk_r[sync_depth-2:0], snes_cpu_clk_in};
      pulse_r   <= {pulse_r[sync_depth-2:0], pulse_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    data_r[0] <= snes_data_in;
    for (int i = 1; i < bus_stages; i++) begin
      addr_r[i] <= addr_r[i-1];
      data_r[i] <= data_r[i-1];
    end
  end

  ////////////////////////////////////////
  // glitch filtered levels
  ////////////////////////////////////////
  assign read_lvl    = read_r[2] & read_r[1];  // a single high sample is dropped
  assign bus.read    = read_lvl;
  assign bus.write   = write_r[2] & write_r[1];
  assign bus.romsel  = romsel_r[2] & romsel_r[1];
  assign bus.cpu_clk = cpu_clk_r[2] & cpu_clk_r[1];
  assign bus.read_narrow = read_lvl | (read_r[5] & read_r[4]);

  assign bus.addr    = addr_r[2] & addr_r[1];
  assign bus.data_in = data_r[2] & data_r[1];

  // edge strobes from the older stages
  assign bus.cycle_start = (cpu_clk_r[6:1] == edge_rise_pat);
  assign bus.rd_start    = (read_r[6:1] == edge_fall_pat);
  assign bus.pulse_end   = (pulse_r[6:1] == pulse_end_pat);

endmodule

/* source/snes_alive_monitor.sv */
`timescale 1ns/100ps

module snes_alive_monitor
  import snes_bus_pkg::*;
(
  input  logic     CLK2,
  input  logic     arst_n,
  snes_bus_if.user bus,
  output logic     dead,
  output logic     revive
);

  logic [dead_cnt_w-1:0] stall_cnt;  // cycles since the CPU clock went low

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      stall_cnt <= '0;
      dead      <= 1'b1;  // console counts as off until its clock runs
      revive    <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (bus.cpu_clk) begin
        stall_cnt <= '0;
        dead      <= 1'b0;
        revive    <= dead;  // first clock high after a dead period
      end else begin
        if (stall_cnt <= dead_cnt_w'(snes_dead_timeout))
          stall_cnt <= stall_cnt + 1'b1;  // stops one past the timeout
        if (stall_cnt > dead_cnt_w'(snes_dead_timeout))
          dead <= 1'b1;
      end
    end
  end

endmodule

/* source/mcu_rom_arbiter.sv */
`timescale 1ns/100ps

module mcu_rom_arbiter
  import rom_pkg::*;
(
  input  logic                  CLK2,
  input  logic                  arst_n,
  snes_bus_if.user              bus,
  input  logic                  dead,
  input  logic                  revive,
  input  logic                  rom_hit,
  input  logic                  mcu_rrq,
  input  logic                  mcu_wrq,
  input  logic [rom_addr_w-1:0] mcu_addr,
  output logic                  mcu_rdy,
  output logic [rom_byte_w-1:0] mcu_din,
  rom_port_if.arb               rom
);

  arb_state_t             state;
  logic [rom_delay_w-1:0] delay_q;
  rom_addr_u              addr_q;
  logic                   rd_pend;
  logic                   wr_pend;
  logic                   free_strobe;
  logic                   free_slot;
  logic                   access_end;
  logic                   done;

  assign access_end = (state == st_rd_end) || (state == st_wr_end);
  assign free_slot  = bus.pulse_end | free_strobe;

  // SNES cycle that does not touch ROM leaves the bus to the MCU
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      free_strobe <= 1'b0;
      done        <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
      done        <= access_end;
    end
  end

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else begin
      if (access_end) begin
        rd_pend <= 1'b0;
        wr_pend <= 1'b0;
      end
      if (done) mcu_rdy <= 1'b1;  // one edge after the end state
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) addr_q.byte_addr <= mcu_addr;
  end

  ////////////////////////////////////////
  // memory cycle FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      delay_q <= '0;
    end else if (revive) begin
      state <= st_idle;  // console came back mid access, start over
    end else begin
      case (state)
        st_idle: begin
          if (free_slot | dead) begin
            if (rd_pend) begin
              state   <= st_rd_addr;
              delay_q <= rom_delay_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state   <= st_wr_addr;
              delay_q <= rom_delay_w'(rom_cycle_len);
            end
          end
        end
        st_rd_addr, st_wr_addr: begin
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0)
            state <= (state == st_rd_addr) ? st_rd_end : st_wr_end;
        end
        default: state <= st_idle;  // end states last one cycle
      endcase
    end
  end

  // last address cycle, the ROM data has settled
  always_ff @(posedge CLK2) begin
    if (state == st_rd_addr && delay_q == '0) mcu_din <= rom.rd_byte;
  end

  assign rom.addr    = addr_q;
  assign rom.mcu_hit = (state != st_idle);
  assign rom.mcu_we  = (state == st_wr_addr);

endmodule

/* source/rom_bus_mux.sv */
`timescale 1ns/100ps

module rom_bus_mux
  import snes_bus_pkg::*;
  import rom_pkg::*;
(
  snes_bus_if.user              bus,
  rom_port_if.mux               rom,
  output logic                  rom_hit,
  input  logic [rom_byte_w-1:0] mcu_dout,
  output logic [rom_addr_w-2:0] rom_addr,
  inout  wire  [rom_word_w-1:0] rom_data,
  output logic                  rom_we,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic                  snes_databus_oe,
  output logic                  snes_databus_dir,
  inout  wire  [snes_data_w-1:0] snes_data
);

  rom_addr_u mapped;    // SNES address after the LoROM fold
  rom_addr_u sel_addr;
  logic      lane_lo;
  logic      snes_rd_rom;

  assign rom_hit = ~bus.romsel;  // every ROMSEL access goes to ROM

  ////////////////////////////////////////
  // address select
  ////////////////////////////////////////
  assign mapped.byte_addr =
    (rom_addr_w'(bus.addr[snes_addr_w-1:16]) << lorom_bank_shift)
    | rom_addr_w'(bus.addr[lorom_bank_shift-1:0]);

  assign sel_addr = rom.mcu_hit ? rom.addr : mapped;
  assign rom_addr = sel_addr.w.word;
  assign lane_lo  = sel_addr.w.lane_lo;

  // byte enables are active low
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  ////////////////////////////////////////
  // ROM data lanes
  ////////////////////////////////////////
  assign rom_data[rom_byte_w-1:0] = (rom.mcu_we & lane_lo) ? mcu_dout : 'z;
  assign rom_data[rom_word_w-1:rom_byte_w] = (rom.mcu_we & ~lane_lo) ? mcu_dout : 'z;
  assign rom_we = ~rom.mcu_we;

  assign rom.rd_byte = lane_lo ? rom_data[rom_byte_w-1:0]
                               : rom_data[rom_word_w-1:rom_byte_w];

  // SNES side, ROM reads only
  assign snes_rd_rom      = rom_hit & ~bus.read;
  assign snes_data        = snes_rd_rom ? rom.rd_byte : 'z;
  assign snes_databus_dir = snes_rd_rom;  // 1 drives toward the console
  assign snes_databus_oe  = bus.romsel | (bus.read_narrow & bus.write);

endmodule

/* source/snes_cart_top.sv */
`timescale 1ns/100ps

module snes_cart_top
  import snes_bus_pkg::*;
  import rom_pkg::*;
(
  input  logic                   CLK2,
  input  logic                   arst_n,
  // SNES cartridge edge
  input  logic [snes_addr_w-1:0] snes_addr_in,
  input  logic                   snes_read_in,
  input  logic                   snes_write_in,
  input  logic                   snes_romsel_in,
  input  logic                   snes_cpu_clk_in,
  inout  wire  [snes_data_w-1:0] snes_data,
  output logic                   snes_databus_oe,
  output logic                   snes_databus_dir,
  // ROM
  output logic [rom_addr_w-2:0]  rom_addr,
  inout  wire  [rom_word_w-1:0]  rom_data,
  output logic                   rom_oe,
  output logic                   rom_we,
  output logic                   rom_bhe,
  output logic                   rom_ble,
  // MCU
  input  logic                   mcu_rrq,
  input  logic                   mcu_wrq,
  input  logic [rom_addr_w-1:0]  mcu_addr,
  input  logic [rom_byte_w-1:0]  mcu_dout,
  output logic                   mcu_rdy,
  output logic [rom_byte_w-1:0]  mcu_din
);

  logic dead;
  logic revive;
  logic rom_hit;

  snes_bus_if bus ();
  rom_port_if rom_port ();

  assign rom_oe = 1'b0;  // outputs stay on, WE takes over for writes

  snes_bus_sync u_sync (
    .CLK2, .arst_n, .snes_addr_in, .snes_data_in(snes_data), .snes_read_in,
    .snes_write_in, .snes_romsel_in, .snes_cpu_clk_in, .bus(bus.sync)
  );

  snes_alive_monitor u_alive (
    .CLK2, .arst_n, .bus(bus.user), .dead, .revive
  );

  mcu_rom_arbiter u_arb (
    .CLK2, .arst_n, .bus(bus.user), .dead, .revive, .rom_hit, .mcu_rrq,
    .mcu_wrq, .mcu_addr, .mcu_rdy, .mcu_din, .rom(rom_port.arb)
  );

  rom_bus_mux u_mux (
    .bus(bus.user), .rom(rom_port.mux), .rom_hit, .mcu_dout, .rom_addr,
    .rom_data, .rom_we, .rom_bhe, .rom_ble, .snes_databus_oe,
    .snes_databus_dir, .snes_data
  );

endmodule

/* bench/snes_cart_props.sv */
`timescale 1ns/100ps

module snes_cart_props (
  input logic CLK2,
  input logic arst_n,
  input logic snes_read_in,
  input logic snes_databus_oe,
  input logic rom_we,
  input logic rom_bhe,
  input logic rom_ble,
  input logic mcu_rdy,
  input logic mcu_lane_lo
);

  int fail_count = 0;  // broken bus rules so far

  // byte enables are active low and never both on
  // on a write the lane follows bit 0 of the MCU address
  lanes_exclusive: assert property (@(posedge CLK2) disable iff (!arst_n)
    (rom_bhe || rom_ble) && (rom_we || (rom_ble == !mcu_lane_lo)))
  else begin
    fail_count++;
    $error("ROM byte lane enables wrong");
  end

  // ROM is written only while an MCU access holds mcu_rdy low
  we_needs_mcu: assert property (@(posedge CLK2) disable iff (!arst_n)
    !rom_we |-> !mcu_rdy)
  else begin
    fail_count++;
    $error("rom_we low without an MCU access");
  end

  // three high samples of read fill the filter, the buffer must be off by then
  oe_off_after_read: assert property (@(posedge CLK2) disable iff (!arst_n)
    snes_read_in && $past(snes_read_in) && $past(snes_read_in, 2) |=> snes_databus_oe)
  else begin
    fail_count++;
    $error("SNES data buffer enabled with read high");
  end

endmodule

bind snes_cart_top snes_cart_props props (
  .CLK2, .arst_n, .snes_read_in, .snes_databus_oe, .rom_we, .rom_bhe, .rom_ble,
  .mcu_rdy, .mcu_lane_lo(mcu_addr[0])
);

/* bench/snes_cart_tb.sv */
`timescale 1ns/100ps

module snes_cart_tb
  import rom_pkg::*;
();

  logic        CLK2;
  logic        arst_n;
  logic [23:0] snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  wire  [7:0]  snes_data;  // only the DUT drives it, the SNES never writes ROM
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  wire  [15:0] rom_data;
  logic        rom_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_dout;
  logic        mcu_rdy;
  logic [7:0]  mcu_din;

  logic [15:0] rom_mem [0:65535];   // ROM model, word addressed
  logic [7:0]  ref_mem [0:131071];  // expected byte per byte address
  logic [16:0] written [$];
  logic [31:0] mcu_seed;
  logic [31:0] snes_seed;
  logic        snes_stop;

  snes_cart_top uut (.*);

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////
  // ROM model
  ////////////////////////////////////////
  assign rom_data = rom_we ? rom_mem[rom_addr[15:0]] : 16'hzzzz;

  always @(posedge CLK2) begin
    if (rom_we === 1'b0) begin
      if (rom_ble === 1'b0) rom_mem[rom_addr[15:0]][7:0] <= rom_data[7:0];
      if (rom_bhe === 1'b0) rom_mem[rom_addr[15:0]][15:8] <= rom_data[15:8];
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [15:0] fill_word(input logic [22:0] waddr);
    return 16'(waddr * 23'd40503) ^ 16'(waddr >> 7) ^ 16'h5a3c;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic halt_on_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      halt_on_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    halt_on_failure();
  endtask

  // stop at the first broken bus rule
  always @(negedge CLK2) begin
    if (uut.props.fail_count != 0) begin
      $display("bus rule assertion failed");
      halt_on_failure();
    end
  end

  // one MCU request, then wait for mcu_rdy and check the result
  task automatic mcu_access(input logic is_write, input logic [16:0] baddr,
                            input logic [7:0] wdata, input logic timed);
    int cycles;
    @(negedge CLK2);
    check_value("mcu_rdy", mcu_rdy, 1'b1);
    mcu_addr = {7'd0, baddr};
    mcu_dout = wdata;
    mcu_wrq  = is_write;
    mcu_rrq  = ~is_write;
    @(negedge CLK2);
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    check_value("mcu_rdy", mcu_rdy, 1'b0);
    cycles = 0;
    while (mcu_rdy !== 1'b1) begin
      @(negedge CLK2);
      cycles++;
      if (cycles > 400) report_timeout("mcu_rdy");
    end
    if (timed) check_value("mcu access cycles", cycles, rom_cycle_len + 4);
    if (is_write) begin
      ref_mem[baddr] = wdata;
      // bit 0 high is the low byte, the other lane stays as it was
      check_value("rom_mem word", rom_mem[baddr[16:1]],
                  {ref_mem[{baddr[16:1], 1'b0}], ref_mem[{baddr[16:1], 1'b1}]});
    end else begin
      check_value("mcu_din", mcu_din, ref_mem[baddr]);
    end
  endtask

  // SNES cycles with a running CPU clock, ROMSEL low on about half of them
  task automatic snes_traffic();
    int hi;
    int lo;
    int n;
    logic [16:0] a;
    n = 0;
    while (!snes_stop && n < 5000) begin
      snes_seed = xorshift32(snes_seed);
      hi = 4 + snes_seed[1:0];
      lo = 3 + snes_seed[3:2];  // five or more low cycles give a cycle start
      a  = snes_seed[20:4];
      @(negedge CLK2);
      snes_cpu_clk_in = 1'b1;
      snes_addr_in    = {6'd0, a[16:15], 1'b1, a[14:0]};
      snes_romsel_in  = snes_seed[21];
      snes_read_in    = 1'b0;
      repeat (hi) @(negedge CLK2);
      snes_cpu_clk_in = 1'b0;  // idle phase, gives the MCU a slot
      snes_read_in    = 1'b1;
      snes_romsel_in  = 1'b1;
      repeat (lo) @(negedge CLK2);
      n++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    int cycles;
    logic [16:0] m;
    arst_n          = 1'b0;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;  // console stays dead until the last part
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = '0;
    mcu_dout        = '0;
    mcu_seed        = 32'd53;
    snes_seed       = 32'd53 ^ 32'h5bd1e995;  // second stream
    snes_stop       = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      rom_mem[i]       = fill_word(23'(i));
      ref_mem[2*i]     = rom_mem[i][15:8];
      ref_mem[2*i + 1] = rom_mem[i][7:0];
    end

    repeat (5) @(posedge CLK2);
    @(negedge CLK2);
    arst_n = 1'b1;
    @(negedge CLK2);
    check_value("mcu_rdy", mcu_rdy, 1'b1);
    check_value("rom_we", rom_we, 1'b1);
    check_value("snes_databus_oe", snes_databus_oe, 1'b1);
    check_value("rom_oe", rom_oe, 1'b0);

    // dead console, fixed access length
    for (int k = 0; k < 20; k++) begin
      mcu_seed = xorshift32(mcu_seed);
      written.push_back(mcu_seed[16:0]);
      mcu_access(1'b1, mcu_seed[16:0], mcu_seed[31:24], 1'b1);
    end
    for (int k = 0; k < 20; k++) begin
      mcu_seed = xorshift32(mcu_seed);
      mcu_access(1'b0, written[mcu_seed[7:0] % written.size()], 8'h00, 1'b1);
    end

    ////////////////////////////////////////
    // SNES reads through the LoROM map
    ////////////////////////////////////////
    for (int k = 0; k < 8; k++) begin
      mcu_seed = xorshift32(mcu_seed);
      m = mcu_seed[0] ? written[mcu_seed[8:1] % written.size()] : mcu_seed[25:9];
      @(negedge CLK2);
      snes_addr_in   = {6'd0, m[16:15], 1'b1, m[14:0]};
      snes_romsel_in = 1'b0;
      snes_read_in   = 1'b0;
      cycles = 0;
      while (snes_databus_oe !== 1'b0) begin
        @(negedge CLK2);
        cycles++;
        if (cycles > 20) report_timeout("snes_databus_oe to go low");
      end
      @(negedge CLK2);
      check_value("snes_data", snes_data, ref_mem[m]);
      check_value("snes_databus_dir", snes_databus_dir, 1'b1);
      check_value("snes_databus_oe", snes_databus_oe, 1'b0);
      snes_romsel_in = 1'b1;
      snes_read_in   = 1'b1;
      cycles = 0;
      while (snes_databus_oe !== 1'b1) begin
        @(negedge CLK2);
        cycles++;
        if (cycles > 20) report_timeout("snes_databus_oe to go high");
      end
    end

    // live console, MCU waits for free slots
    fork
      snes_traffic();
      begin
        for (int k = 0; k < 20; k++) begin
          mcu_seed = xorshift32(mcu_seed);
          mcu_access(1'b0, written[mcu_seed[7:0] % written.size()], 8'h00, 1'b0);
        end
        snes_stop = 1'b1;
      end
    join

    repeat (4) @(negedge CLK2);
    if (uut.props.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("bus rule assertions failed");
      halt_on_failure();
    end
  end

endmodule

/* files.f */
source/snes_bus_pkg.sv
source/rom_pkg.sv
source/snes_bus_if.sv
source/rom_port_if.sv
source/snes_bus_sync.sv
source/snes_alive_monitor.sv
source/mcu_rom_arbiter.sv
source/rom_bus_mux.sv
source/snes_cart_top.sv
bench/snes_cart_props.sv
bench/snes_cart_tb.sv
